//--- project.f
+incdir+rtl
rtl/frame_buffer_pkg.sv
rtl/fb_addr_decoder.sv
rtl/fb_bank_ram.sv
rtl/fb_bank_array.sv
rtl/fb_read_mux.sv
rtl/frame_buffer_top.sv
bench/frame_buffer_assertions.sv
bench/tb_clock_gen.sv
bench/frame_buffer_tb.sv

//--- run_sim.sh
#!/bin/sh
# compile and run the frame buffer testbench with Verilator
# exit status 0 only when the run passed

cd "$(dirname "$0")" || exit 1

top=frame_buffer_tb
build_dir=obj_dir
log=sim.log
fail_msg="TEST RESULT: FAIL"
pass_msg="TEST RESULT: PASS"

rm -rf "$build_dir" "$log"
if [ $? -ne 0 ]; then
    echo "could not clean the previous build"
    exit 1
fi

verilator --binary --timing --assert \
    --timescale 1ns/1ns \
    --top-module "$top" \
    --Mdir "$build_dir" \
    -f project.f
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

"./$build_dir/V$top" +verilator+error+limit+100 > "$log" 2>&1
run_status=$?
cat "$log"

if grep -q "$fail_msg" "$log"; then
    echo "simulation reported a failure"
    exit 1
fi
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi
if ! grep -q "$pass_msg" "$log"; then
    echo "no result line found in $log"
    exit 1
fi
echo "simulation passed"
exit 0

//--- bench/frame_buffer_tb.sv
`timescale 1ns/1ns
`include "frame_buffer_cfg.svh"

module frame_buffer_tb;

    localparam int CLK_PERIOD  = 100;
    localparam int WORDS       = `FB_NUM_BANKS * `FB_BANK_DEPTH;
    localparam int RAND_CYCLES = 200;
    // fill and full re-read dominate the cycle count
    localparam int TEST_CYCLES   = 2 * WORDS + 6 * `FB_NUM_BANKS + RAND_CYCLES + 40;
    localparam int MARGIN_CYCLES = 200;
    // parked read address past the last bank
    localparam frame_buffer_pkg::fb_addr_t IDLE_ADDR = '1;

    logic                         clk;
    logic                         resetn;
    frame_buffer_pkg::fb_wr_req_t wr_req;
    frame_buffer_pkg::fb_addr_t   rd0_addr;
    frame_buffer_pkg::fb_addr_t   rd1_addr;
    frame_buffer_pkg::fb_data_t   rd0_data;
    frame_buffer_pkg::fb_data_t   rd1_data;

    // shadow of the memory by global address
    frame_buffer_pkg::fb_data_t model [1 << `FB_ADDR_WIDTH];

    // reads of the previous cycle awaiting their check
    bit                         pend0_valid = 1'b0;
    bit                         pend1_valid = 1'b0;
    frame_buffer_pkg::fb_addr_t pend0_addr;
    frame_buffer_pkg::fb_addr_t pend1_addr;
    frame_buffer_pkg::fb_data_t pend0_exp;
    frame_buffer_pkg::fb_data_t pend1_exp;

    int error_count  = 0;
    int check_count  = 0;
    int tests_run    = 0;
    int tests_failed = 0;

    tb_clock_gen #(.PERIOD_NS(CLK_PERIOD), .RESET_CYCLES(2)) i_clock_gen (
        .clk_o    (clk),
        .resetn_o (resetn)
    );

    frame_buffer_top i_dut (
        .clk_i      (clk),
        .resetn_i   (resetn),
        .wr_req_i   (wr_req),
        .rd0_addr_i (rd0_addr),
        .rd1_addr_i (rd1_addr),
        .rd0_data_o (rd0_data),
        .rd1_data_o (rd1_data)
    );

    ////////////////////////////////////////////////////////////
    // expected values
    ////////////////////////////////////////////////////////////

    function automatic bit in_range(input frame_buffer_pkg::fb_addr_t addr);
        return int'(addr) < WORDS;
    endfunction

    // one bit per bank and none past the last bank
    function automatic frame_buffer_pkg::fb_bank_sel_t expected_sel(
        input frame_buffer_pkg::fb_addr_t addr);
        int bank;
        bank = int'(addr) / `FB_BANK_DEPTH;
        if (bank < `FB_NUM_BANKS) begin
            return frame_buffer_pkg::fb_bank_sel_t'(1) << bank;
        end
        return '0;
    endfunction

    function automatic frame_buffer_pkg::fb_data_t expected_read(
        input frame_buffer_pkg::fb_addr_t addr);
        if (in_range(addr)) begin
            return model[addr];
        end
        return '0;
    endfunction

    function automatic frame_buffer_pkg::fb_addr_t bank_addr(input int bank, input int offset);
        return frame_buffer_pkg::fb_addr_t'(bank * `FB_BANK_DEPTH + offset);
    endfunction

    // odd multiplier spreads every address bit into the word
    function automatic frame_buffer_pkg::fb_data_t fill_word(
        input frame_buffer_pkg::fb_addr_t addr);
        return frame_buffer_pkg::fb_data_t'((int'(addr) * 40503) ^ 'h5A3C);
    endfunction

    function automatic frame_buffer_pkg::fb_wr_req_t make_write(
        input frame_buffer_pkg::fb_addr_t addr, input frame_buffer_pkg::fb_data_t data);
        frame_buffer_pkg::fb_wr_req_t req;
        req.wr   = 1'b1;
        req.addr = addr;
        req.data = data;
        return req;
    endfunction

    function automatic frame_buffer_pkg::fb_wr_req_t no_write();
        return '0;
    endfunction

    // one pick in four spans the whole address space
    function automatic frame_buffer_pkg::fb_addr_t random_addr();
        if ($urandom_range(0, 3) == 0) begin
            return frame_buffer_pkg::fb_addr_t'($urandom);
        end
        return frame_buffer_pkg::fb_addr_t'($urandom_range(0, WORDS - 1));
    endfunction

    ////////////////////////////////////////////////////////////
    // compare tasks and cycle driver
    ////////////////////////////////////////////////////////////

    task automatic check_data(input string name, input frame_buffer_pkg::fb_data_t got,
                              input frame_buffer_pkg::fb_data_t exp,
                              input frame_buffer_pkg::fb_addr_t addr);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("ERROR %s: got 0x%h, expected 0x%h, address 0x%h", name, got, exp, addr);
        end
    endtask

    task automatic check_sel(input string name, input frame_buffer_pkg::fb_bank_sel_t got,
                             input frame_buffer_pkg::fb_bank_sel_t exp,
                             input frame_buffer_pkg::fb_addr_t addr);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("ERROR %s: got 0x%h, expected 0x%h, address 0x%h", name, got, exp, addr);
        end
    endtask

    // drives one cycle and checks the previous cycle's reads at mid-cycle
    task automatic run_cycle(input frame_buffer_pkg::fb_wr_req_t wr,
                             input frame_buffer_pkg::fb_addr_t ra0, input bit chk0,
                             input frame_buffer_pkg::fb_addr_t ra1, input bit chk1);
        @(posedge clk);
        wr_req   <= wr;
        rd0_addr <= ra0;
        rd1_addr <= ra1;
        @(negedge clk);
        if (pend0_valid) begin
            check_data("rd0_data_o", rd0_data, pend0_exp, pend0_addr);
        end
        if (pend1_valid) begin
            check_data("rd1_data_o", rd1_data, pend1_exp, pend1_addr);
        end
        if (wr.wr) begin
            check_sel("wr_req.sel", i_dut.wr_req.sel, expected_sel(wr.addr), wr.addr);
        end
        // read-first order means expectations precede this cycle's write
        pend0_valid = chk0;
        pend0_addr  = ra0;
        pend0_exp   = expected_read(ra0);
        pend1_valid = chk1;
        pend1_addr  = ra1;
        pend1_exp   = expected_read(ra1);
        if (wr.wr && in_range(wr.addr)) begin
            model[wr.addr] = wr.data;
        end
    endtask

    // idle cycle that collects the last pending results
    task automatic flush();
        run_cycle(no_write(), IDLE_ADDR, 1'b0, IDLE_ADDR, 1'b0);
    endtask

    task automatic finish_test(input string name, input int errors_before);
        tests_run++;
        if (error_count == errors_before) begin
            $display("%s: ok", name);
        end else begin
            tests_failed++;
            $display("%s: %0d errors", name, error_count - errors_before);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // tests
    ////////////////////////////////////////////////////////////

    task automatic test_reset_outputs();
        int errs;
        errs = error_count;
        // first cycle after release, selects still hold their reset value
        wait (resetn === 1'b1);
        @(negedge clk);
        check_data("rd0_data_o", rd0_data, '0, rd0_addr);
        check_data("rd1_data_o", rd1_data, '0, rd1_addr);
        finish_test("test 1 reset outputs", errs);
    endtask

    // every word gets a known value before the read tests
    task automatic fill_memory();
        for (int a = 0; a < WORDS; a++) begin
            run_cycle(make_write(frame_buffer_pkg::fb_addr_t'(a),
                                 fill_word(frame_buffer_pkg::fb_addr_t'(a))),
                      IDLE_ADDR, 1'b0, IDLE_ADDR, 1'b0);
        end
        flush();
    endtask

    task automatic test_bank_edges();
        int errs;
        int offs [3];
        errs = error_count;
        // first, middle and last word of a bank
        offs = '{0, `FB_BANK_DEPTH / 2, `FB_BANK_DEPTH - 1};
        for (int k = 0; k < `FB_NUM_BANKS; k++) begin
            for (int j = 0; j < 3; j++) begin
                run_cycle(make_write(bank_addr(k, offs[j]),
                                     frame_buffer_pkg::fb_data_t'('hA000 + (k << 4) + j)),
                          IDLE_ADDR, 1'b0, IDLE_ADDR, 1'b0);
            end
        end
        for (int k = 0; k < `FB_NUM_BANKS; k++) begin
            for (int j = 0; j < 3; j++) begin
                run_cycle(no_write(), bank_addr(k, offs[j]), 1'b1, IDLE_ADDR, 1'b0);
            end
        end
        flush();
        finish_test("test 2 bank edges", errs);
    endtask

    task automatic test_dual_read();
        int errs;
        errs = error_count;
        // different banks first and then two words of one bank
        run_cycle(no_write(), bank_addr(0, 0), 1'b1, bank_addr(1, `FB_BANK_DEPTH - 1), 1'b1);
        run_cycle(no_write(), bank_addr(2, `FB_BANK_DEPTH / 2), 1'b1, bank_addr(3, 0), 1'b1);
        run_cycle(no_write(), bank_addr(1, 0), 1'b1, bank_addr(1, `FB_BANK_DEPTH / 2), 1'b1);
        run_cycle(no_write(), bank_addr(3, `FB_BANK_DEPTH - 1), 1'b1, bank_addr(0, 7), 1'b1);
        flush();
        finish_test("test 3 dual read", errs);
    endtask

    task automatic test_out_of_range();
        int errs;
        errs = error_count;
        run_cycle(make_write(frame_buffer_pkg::fb_addr_t'(WORDS), 'hDEAD),
                  IDLE_ADDR, 1'b0, IDLE_ADDR, 1'b0);
        run_cycle(make_write(frame_buffer_pkg::fb_addr_t'(WORDS + 5), 'hBEEF),
                  IDLE_ADDR, 1'b0, IDLE_ADDR, 1'b0);
        run_cycle(make_write(IDLE_ADDR, 'hF00D), IDLE_ADDR, 1'b0, IDLE_ADDR, 1'b0);
        // an aliasing write shows up here
        // port 1 walks the space backwards
        for (int a = 0; a < WORDS; a++) begin
            run_cycle(no_write(), frame_buffer_pkg::fb_addr_t'(a), 1'b1,
                      frame_buffer_pkg::fb_addr_t'(WORDS - 1 - a), 1'b1);
        end
        run_cycle(no_write(), frame_buffer_pkg::fb_addr_t'(WORDS), 1'b1, IDLE_ADDR, 1'b1);
        flush();
        finish_test("test 4 out of range", errs);
    endtask

    task automatic test_read_during_write();
        int errs;
        frame_buffer_pkg::fb_addr_t addr;
        errs = error_count;
        addr = bank_addr(2, 17);
        run_cycle(make_write(addr, 'h1234), IDLE_ADDR, 1'b0, addr, 1'b1);
        run_cycle(no_write(), IDLE_ADDR, 1'b0, addr, 1'b1);
        flush();
        finish_test("test 5 read during write", errs);
    endtask

    task automatic test_random_traffic();
        int errs;
        frame_buffer_pkg::fb_wr_req_t wr;
        errs = error_count;
        for (int n = 0; n < RAND_CYCLES; n++) begin
            wr = no_write();
            if ($urandom_range(0, 1) == 1) begin
                wr = make_write(random_addr(), frame_buffer_pkg::fb_data_t'($urandom));
            end
            run_cycle(wr, random_addr(), 1'b1, random_addr(), 1'b1);
        end
        flush();
        finish_test("test 6 random traffic", errs);
    endtask

    ////////////////////////////////////////////////////////////
    // sequence and watchdog
    ////////////////////////////////////////////////////////////

    initial begin
        int assert_fails;
        void'($urandom(85251));
        wr_req   = '0;
        // reads held in range while reset is low
        rd0_addr = bank_addr(0, 0);
        rd1_addr = bank_addr(1, 0);
        test_reset_outputs();
        fill_memory();
        test_bank_edges();
        test_dual_read();
        test_out_of_range();
        test_read_during_write();
        test_random_traffic();
        assert_fails = i_dut.i_assertions.fail_count;
        $display("summary: %0d tests, %0d failed, %0d checks, %0d errors, %0d assertion failures",
                 tests_run, tests_failed, check_count, error_count, assert_fails);
        if ((error_count == 0) && (tests_failed == 0) && (assert_fails == 0)) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    initial begin
        #((TEST_CYCLES + MARGIN_CYCLES) * CLK_PERIOD);
        $display("watchdog expired, the tests did not finish in time");
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

//--- bench/tb_clock_gen.sv
`timescale 1ns/1ns

// testbench clock and synchronous active-low reset
module tb_clock_gen #(
    parameter int PERIOD_NS    = 100,
    parameter int RESET_CYCLES = 2
) (
    output logic clk_o,
    output logic resetn_o
);

    // free-running clock, first rising edge at half a period
    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

    // reset released on a rising edge, like every other input
    initial begin
        resetn_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        resetn_o <= 1'b1;
    end

endmodule

//--- bench/frame_buffer_assertions.sv
`timescale 1ns/1ns
`include "frame_buffer_cfg.svh"

// decode and read-path checks on the frame buffer top level
module frame_buffer_assertions (
    input logic                           clk_i,
    input logic                           resetn_i,
    input frame_buffer_pkg::fb_bank_sel_t wr_sel_i,
    input frame_buffer_pkg::fb_addr_t     rd0_addr_i,
    input frame_buffer_pkg::fb_addr_t     rd1_addr_i,
    input frame_buffer_pkg::fb_data_t     rd0_data_i,
    input frame_buffer_pkg::fb_data_t     rd1_data_i
);

    // first global address past the last bank
    localparam int WORDS = `FB_NUM_BANKS * `FB_BANK_DEPTH;

    // failures so far, summed into the final result by the testbench
    int fail_count = 0;

    // write decode names one bank at most
    wr_sel_onehot: assert property (@(posedge clk_i) $onehot0(wr_sel_i))
    else begin
        fail_count++;
        $error("write bank select 0x%h is not one-hot or zero", wr_sel_i);
    end

    // out-of-range read gives zero one cycle later
    rd0_oor_zero: assert property (@(posedge clk_i) disable iff (!resetn_i)
        (int'(rd0_addr_i) >= WORDS) |=> (rd0_data_i == '0))
    else begin
        fail_count++;
        $error("rd0_data_o is 0x%h after an out-of-range address", rd0_data_i);
    end

    rd1_oor_zero: assert property (@(posedge clk_i) disable iff (!resetn_i)
        (int'(rd1_addr_i) >= WORDS) |=> (rd1_data_i == '0))
    else begin
        fail_count++;
        $error("rd1_data_o is 0x%h after an out-of-range address", rd1_data_i);
    end

    // selects are cleared by reset, so both outputs start at zero
    reset_outputs_zero: assert property (@(posedge clk_i)
        $rose(resetn_i) |-> ((rd0_data_i == '0) && (rd1_data_i == '0)))
    else begin
        fail_count++;
        $error("read outputs not zero in the first cycle after reset");
    end

endmodule

bind frame_buffer_top frame_buffer_assertions i_assertions (
    .clk_i      (clk_i),
    .resetn_i   (resetn_i),
    .wr_sel_i   (wr_req.sel),
    .rd0_addr_i (rd0_addr_i),
    .rd1_addr_i (rd1_addr_i),
    .rd0_data_i (rd0_data_o),
    .rd1_data_i (rd1_data_o)
);

//--- rtl/frame_buffer_top.sv
`timescale 1ns/1ns
`include "frame_buffer_cfg.svh"

// banked frame buffer
// one write port, two independent read ports,
// one shared global pixel address space
module frame_buffer_top (
    input  logic                         clk_i,
    input  logic                         resetn_i,

    // write port: strobe, global address, pixel
    input  frame_buffer_pkg::fb_wr_req_t wr_req_i,

    // read ports, data one cycle after the address
    input  frame_buffer_pkg::fb_addr_t   rd0_addr_i,
    input  frame_buffer_pkg::fb_addr_t   rd1_addr_i,
    output frame_buffer_pkg::fb_data_t   rd0_data_o,
    output frame_buffer_pkg::fb_data_t   rd1_data_o
);

    // decoded ports
    frame_buffer_pkg::fb_bank_req_t  wr_req;
    frame_buffer_pkg::fb_bank_req_t  rd0_req;
    frame_buffer_pkg::fb_bank_req_t  rd1_req;

    // registered bank words per read port
    frame_buffer_pkg::fb_bank_data_t rd0_bank;
    frame_buffer_pkg::fb_bank_data_t rd1_bank;

    ////////////////////////////////////////////////////////////
    // address decode
    ////////////////////////////////////////////////////////////

    // write
    fb_addr_decoder i_wr_decoder (
        .addr_i (wr_req_i.addr),
        .req_o  (wr_req)
    );

    // read port 0
    fb_addr_decoder i_rd0_decoder (
        .addr_i (rd0_addr_i),
        .req_o  (rd0_req)
    );

    // read port 1
    fb_addr_decoder i_rd1_decoder (
        .addr_i (rd1_addr_i),
        .req_o  (rd1_req)
    );

    ////////////////////////////////////////////////////////////
    // banks
    ////////////////////////////////////////////////////////////

    fb_bank_array i_bank_array (
        .clk_i      (clk_i),
        .wr_i       (wr_req_i.wr),
        .wr_data_i  (wr_req_i.data),
        .wr_req_i   (wr_req),
        .rd0_req_i  (rd0_req),
        .rd1_req_i  (rd1_req),
        .rd0_bank_o (rd0_bank),
        .rd1_bank_o (rd1_bank)
    );

    ////////////////////////////////////////////////////////////
    // output select, one mux per read port
    ////////////////////////////////////////////////////////////

    fb_read_mux i_rd0_mux (
        .clk_i       (clk_i),
        .resetn_i    (resetn_i),
        .sel_i       (rd0_req.sel),
        .bank_data_i (rd0_bank),
        .data_o      (rd0_data_o)
    );

    fb_read_mux i_rd1_mux (
        .clk_i       (clk_i),
        .resetn_i    (resetn_i),
        .sel_i       (rd1_req.sel),
        .bank_data_i (rd1_bank),
        .data_o      (rd1_data_o)
    );

endmodule

//--- rtl/fb_read_mux.sv
`timescale 1ns/1ns
`include "frame_buffer_cfg.svh"

// picks one bank word for a read port
// select registered alongside the bank data, so both line up
module fb_read_mux (
    input  logic                            clk_i,
    input  logic                            resetn_i,

    // select of the address presented this cycle
    input  frame_buffer_pkg::fb_bank_sel_t  sel_i,
    // bank words for the address of the previous cycle
    input  frame_buffer_pkg::fb_bank_data_t bank_data_i,

    output frame_buffer_pkg::fb_data_t      data_o
);

    ////////////////////////////////////////////////////////////
    // select register
    ////////////////////////////////////////////////////////////

    // which bank was addressed one cycle ago
    frame_buffer_pkg::fb_bank_sel_t sel_q;

    always_ff @(posedge clk_i) begin
        if (!resetn_i) begin
            sel_q <= '0;
        end else begin
            sel_q <= sel_i;
        end
    end

    ////////////////////////////////////////////////////////////
    // or-mux
    ////////////////////////////////////////////////////////////

    // select is one-hot or zero, so the or gives
    // the addressed word, or zero when out of range
    always_comb begin
        data_o = '0;
        for (int k = 0; k < `FB_NUM_BANKS; k++) begin
            if (sel_q[k]) begin
                data_o = data_o | bank_data_i[k];
            end
        end
    end

endmodule

//--- rtl/fb_bank_array.sv
`timescale 1ns/1ns
`include "frame_buffer_cfg.svh"

// all banks of the frame buffer
// write strobe gated per bank, read words collected per port
module fb_bank_array (
    input  logic                            clk_i,

    // write strobe and payload
    input  logic                            wr_i,
    input  frame_buffer_pkg::fb_data_t      wr_data_i,

    // decoded ports
    input  frame_buffer_pkg::fb_bank_req_t  wr_req_i,
    input  frame_buffer_pkg::fb_bank_req_t  rd0_req_i,
    input  frame_buffer_pkg::fb_bank_req_t  rd1_req_i,

    // one word per bank and port, one cycle after the address
    output frame_buffer_pkg::fb_bank_data_t rd0_bank_o,
    output frame_buffer_pkg::fb_bank_data_t rd1_bank_o
);

    ////////////////////////////////////////////////////////////
    // bank instances
    ////////////////////////////////////////////////////////////

    for (genvar k = 0; k < `FB_NUM_BANKS; k++) begin : g_bank
        // write only into the addressed bank
        logic                             bank_wr;
        // read addresses, parked at zero on banks not addressed
        frame_buffer_pkg::fb_local_addr_t bank_rd0_addr;
        frame_buffer_pkg::fb_local_addr_t bank_rd1_addr;

        assign bank_wr = wr_i & wr_req_i.sel[k];

        // cuts toggling on idle banks, the read mux
        // ignores their words anyway
        assign bank_rd0_addr = rd0_req_i.sel[k] ? rd0_req_i.local_addr : '0;
        assign bank_rd1_addr = rd1_req_i.sel[k] ? rd1_req_i.local_addr : '0;

        fb_bank_ram i_bank_ram (
            .clk_i      (clk_i),
            .wr_i       (bank_wr),
            .wr_addr_i  (wr_req_i.local_addr),
            .wr_data_i  (wr_data_i),
            .rd0_addr_i (bank_rd0_addr),
            .rd1_addr_i (bank_rd1_addr),
            .rd0_data_o (rd0_bank_o[k]),
            .rd1_data_o (rd1_bank_o[k])
        );
    end

endmodule

//--- rtl/fb_bank_ram.sv
`timescale 1ns/1ns
`include "frame_buffer_cfg.svh"

// one memory bank
// one write port, two registered read ports
module fb_bank_ram (
    input  logic                             clk_i,

    // write side
    input  logic                             wr_i,
    input  frame_buffer_pkg::fb_local_addr_t wr_addr_i,
    input  frame_buffer_pkg::fb_data_t       wr_data_i,

    // read side
    input  frame_buffer_pkg::fb_local_addr_t rd0_addr_i,
    input  frame_buffer_pkg::fb_local_addr_t rd1_addr_i,
    output frame_buffer_pkg::fb_data_t       rd0_data_o,
    output frame_buffer_pkg::fb_data_t       rd1_data_o
);

    ////////////////////////////////////////////////////////////
    // storage
    ////////////////////////////////////////////////////////////

    // maps onto a block ram, contents undefined at start
    frame_buffer_pkg::fb_data_t mem [`FB_BANK_DEPTH];

    ////////////////////////////////////////////////////////////
    // write and registered reads
    ////////////////////////////////////////////////////////////

    // read-first: a read of the address being written
    // in the same cycle sees the old word
    always_ff @(posedge clk_i) begin
        if (wr_i) begin
            mem[wr_addr_i] <= wr_data_i;
        end
        // port 0
        rd0_data_o <= mem[rd0_addr_i];
        // port 1
        rd1_data_o <= mem[rd1_addr_i];
    end

endmodule

//--- rtl/fb_addr_decoder.sv
`timescale 1ns/1ns
`include "frame_buffer_cfg.svh"

// global address to bank select plus bank-local address
// purely combinational
module fb_addr_decoder (
    input  frame_buffer_pkg::fb_addr_t     addr_i,
    output frame_buffer_pkg::fb_bank_req_t req_o
);

    // bank size, 32 bits so the range math never wraps
    localparam logic [31:0] DEPTH = 32'(`FB_BANK_DEPTH);

    // zero-extended copy of the address
    logic [31:0] addr_ext;
    // start of the bank under test in the loop
    logic [31:0] base;
    // distance from that start
    logic [31:0] offset;

    assign addr_ext = 32'(addr_i);

    always_comb begin
        // default: no bank, local address parked at zero
        req_o  = '0;
        base   = '0;
        offset = '0;
        for (int k = 0; k < `FB_NUM_BANKS; k++) begin
            base = 32'(k) * DEPTH;
            // bank k owns [k*depth, (k+1)*depth)
            if ((addr_ext >= base) && (addr_ext < (base + DEPTH))) begin
                req_o.sel[k]     = 1'b1;
                offset           = addr_ext - base;
                req_o.local_addr = offset[`FB_LOCAL_WIDTH-1:0];
            end
        end
    end

    // past the last bank the loop never matches,
    // sel stays all zero so writes drop and reads return zero

endmodule

//--- rtl/frame_buffer_pkg.sv
`include "frame_buffer_cfg.svh"

package frame_buffer_pkg;

    ////////////////////////////////////////////////////////////
    // scalar types
    ////////////////////////////////////////////////////////////

    // global pixel address
    typedef logic [`FB_ADDR_WIDTH-1:0] fb_addr_t;

    // address inside one bank
    typedef logic [`FB_LOCAL_WIDTH-1:0] fb_local_addr_t;

    // one pixel word
    typedef logic [`FB_DATA_WIDTH-1:0] fb_data_t;

    // one-hot bank select, all zero when out of range
    typedef logic [`FB_NUM_BANKS-1:0] fb_bank_sel_t;

    // read words of every bank, index = bank number
    typedef fb_data_t [`FB_NUM_BANKS-1:0] fb_bank_data_t;

    ////////////////////////////////////////////////////////////
    // port bundles
    ////////////////////////////////////////////////////////////

    // write port as seen at the top level
    typedef struct packed {
        logic     wr;
        fb_addr_t addr;
        fb_data_t data;
    } fb_wr_req_t;

    // one decoded port
    typedef struct packed {
        fb_bank_sel_t   sel;
        fb_local_addr_t local_addr;
    } fb_bank_req_t;

endpackage

//--- rtl/frame_buffer_cfg.svh
`ifndef FRAME_BUFFER_CFG_SVH
`define FRAME_BUFFER_CFG_SVH

////////////////////////////////////////////////////////////
// frame buffer sizing
////////////////////////////////////////////////////////////

// one pixel word
`define FB_DATA_WIDTH   16

// global pixel address, wider than the populated space
// so addresses past the last bank exist
`define FB_ADDR_WIDTH   12

// bank count and words per bank
`define FB_NUM_BANKS    4
`define FB_BANK_DEPTH   256

// bank-local address, log2 of the depth
`define FB_LOCAL_WIDTH  $clog2(`FB_BANK_DEPTH)

`endif
